// File: run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module ifft_tb -Mdir obj_dir -o ifft_sim &&
	./obj_dir/ifft_sim ||
	exit 1

// File: sim.f
source/ifft_pkg.sv
source/ifft_ctrl.sv
source/ifft_step_counter.sv
source/ifft_sample_bank.sv
source/ifft_butterfly.sv
source/ifft_unload.sv
source/ifft.sv
verification/ifft_sva.sv
verification/ifft_tb.sv

// File: source/ifft.sv
// no back-pressure; samples pushed while computing or unloading are dropped
module ifft
	import ifft_pkg::*;
#(
	parameter int BFY_LATENCY = 3
) (
	input  logic clk,
	input  logic rst,
	input  logic pushin,
	input  io_t  dir,
	input  io_t  dii,
	output logic pushout,
	output io_t  dor,
	output io_t  doi
);

	ctrl_state_e state;
	logic phase_done;
	logic issue;
	addr_t wr_addr;
	addr_t rd_addr_a;
	addr_t rd_addr_b;
	tw_idx_t tw_idx;
	acc_t rd_ar;
	acc_t rd_ai;
	acc_t rd_br;
	acc_t rd_bi;
	logic wb_valid;
	addr_t wb_addr_a;
	addr_t wb_addr_b;
	acc_t wb_ar;
	acc_t wb_ai;
	acc_t wb_br;
	acc_t wb_bi;

	ifft_ctrl ctrl_i (
		.clk(clk),
		.rst(rst),
		.phase_done(phase_done),
		.state(state)
	);

	ifft_step_counter #(
		.BFY_LATENCY(BFY_LATENCY)
	) step_i (
		.clk(clk),
		.rst(rst),
		.state(state),
		.pushin(pushin),
		.wr_addr(wr_addr),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.tw_idx(tw_idx),
		.issue(issue),
		.phase_done(phase_done)
	);

	ifft_sample_bank bank_i (
		.clk(clk),
		.rst(rst),
		.state(state),
		.pushin(pushin),
		.wr_addr(wr_addr),
		.dir(dir),
		.dii(dii),
		.rd_addr_a(rd_addr_a),
		.rd_addr_b(rd_addr_b),
		.wb_valid(wb_valid),
		.wb_addr_a(wb_addr_a),
		.wb_addr_b(wb_addr_b),
		.wb_ar(wb_ar),
		.wb_ai(wb_ai),
		.wb_br(wb_br),
		.wb_bi(wb_bi),
		.rd_ar(rd_ar),
		.rd_ai(rd_ai),
		.rd_br(rd_br),
		.rd_bi(rd_bi)
	);

	ifft_butterfly #(
		.BFY_LATENCY(BFY_LATENCY)
	) bfy_i (
		.clk(clk),
		.rst(rst),
		.issue(issue),
		.a_r(rd_ar),
		.a_i(rd_ai),
		.b_r(rd_br),
		.b_i(rd_bi),
		.tw_idx(tw_idx),
		.addr_a(rd_addr_a),
		.addr_b(rd_addr_b),
		.wb_valid(wb_valid),
		.wb_addr_a(wb_addr_a),
		.wb_addr_b(wb_addr_b),
		.wb_ar(wb_ar),
		.wb_ai(wb_ai),
		.wb_br(wb_br),
		.wb_bi(wb_bi)
	);

	ifft_unload unload_i (
		.clk(clk),
		.rst(rst),
		.state(state),
		.rd_ar(rd_ar),
		.rd_ai(rd_ai),
		.pushout(pushout),
		.dor(dor),
		.doi(doi)
	);

endmodule

// File: source/ifft_butterfly.sv
// needs BFY_LATENCY >= 2; sum and product wrap to 36 bits with no overflow flag
module ifft_butterfly
	import ifft_pkg::*;
#(
	parameter int BFY_LATENCY = 3
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    issue,
	input  acc_t    a_r,
	input  acc_t    a_i,
	input  acc_t    b_r,
	input  acc_t    b_i,
	input  tw_idx_t tw_idx,
	input  addr_t   addr_a,
	input  addr_t   addr_b,
	output logic    wb_valid,
	output addr_t   wb_addr_a,
	output addr_t   wb_addr_b,
	output acc_t    wb_ar,
	output acc_t    wb_ai,
	output acc_t    wb_br,
	output acc_t    wb_bi
);

	localparam int TAIL = BFY_LATENCY - 1;
	localparam int PROD_W = ACC_W + TW_W + 1;

	logic v1;
	addr_t wa1;
	addr_t wb1;
	acc_t sum_r1;
	acc_t sum_i1;
	acc_t dif_r1;
	acc_t dif_i1;
	logic signed [TW_W-1:0] tw_c1;
	logic signed [TW_W-1:0] tw_s1;
	logic signed [PROD_W-1:0] prod_r;
	logic signed [PROD_W-1:0] prod_i;

	logic v_q [TAIL];
	addr_t wa_q [TAIL];
	addr_t wb_q [TAIL];
	acc_t ar_q [TAIL];
	acc_t ai_q [TAIL];
	acc_t br_q [TAIL];
	acc_t bi_q [TAIL];

	// first stage: add, subtract, twiddle lookup
	always_ff @(posedge clk) begin
		sum_r1 <= a_r + b_r;
		sum_i1 <= a_i + b_i;
		dif_r1 <= a_r - b_r;
		dif_i1 <= a_i - b_i;
		tw_c1 <= TW_COS[tw_idx];
		tw_s1 <= TW_SIN[tw_idx];
		wa1 <= addr_a;
		wb1 <= addr_b;
	end

	// (dr + j di)(c + j s)
	assign prod_r = dif_r1 * tw_c1 - dif_i1 * tw_s1;
	assign prod_i = dif_r1 * tw_s1 + dif_i1 * tw_c1;

	always_ff @(posedge clk) begin
		if (rst) begin
			v1 <= 1'b0;
			for (int i = 0; i < TAIL; i++) begin
				v_q[i] <= 1'b0;
			end
		end else begin
			v1 <= issue;
			v_q[0] <= v1;
			for (int i = 1; i < TAIL; i++) begin
				v_q[i] <= v_q[i-1];
			end
		end
	end

	// floor shift by TW_FRAC is just the upper slice
	always_ff @(posedge clk) begin
		wa_q[0] <= wa1;
		wb_q[0] <= wb1;
		ar_q[0] <= sum_r1;
		ai_q[0] <= sum_i1;
		br_q[0] <= prod_r[TW_FRAC +: ACC_W];
		bi_q[0] <= prod_i[TW_FRAC +: ACC_W];
		for (int i = 1; i < TAIL; i++) begin
			wa_q[i] <= wa_q[i-1];
			wb_q[i] <= wb_q[i-1];
			ar_q[i] <= ar_q[i-1];
			ai_q[i] <= ai_q[i-1];
			br_q[i] <= br_q[i-1];
			bi_q[i] <= bi_q[i-1];
		end
	end

	assign wb_valid = v_q[TAIL-1];
	assign wb_addr_a = wa_q[TAIL-1];
	assign wb_addr_b = wb_q[TAIL-1];
	assign wb_ar = ar_q[TAIL-1];
	assign wb_ai = ai_q[TAIL-1];
	assign wb_br = br_q[TAIL-1];
	assign wb_bi = bi_q[TAIL-1];

endmodule

// File: source/ifft_ctrl.sv
// phases advance only on phase_done; there is no abort path back to load except reset
module ifft_ctrl
	import ifft_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  logic        phase_done,
	output ctrl_state_e state
);

	ctrl_state_e state_nxt;

	// load -> compute -> unload -> load
	always_comb begin
		state_nxt = state;
		if (phase_done) begin
			case (state)
				ST_LOAD: begin
					state_nxt = ST_COMPUTE;
				end
				ST_COMPUTE: begin
					state_nxt = ST_UNLOAD;
				end
				ST_UNLOAD: begin
					state_nxt = ST_LOAD;
				end
				default: begin
					state_nxt = ST_LOAD;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_LOAD;
		end else begin
			state <= state_nxt;
		end
	end

endmodule

// File: source/ifft_pkg.sv
// fixed 32-point frame only; Q4.24 ports, 36-bit datapath, Q1.16 twiddles for the inverse transform
package ifft_pkg;

	localparam int N_POINTS = 32;
	localparam int LOG2_N = 5;
	localparam int N_BFY = 16;

	localparam int IO_W = 28;
	localparam int ACC_W = 36;
	localparam int GUARD_BITS = 4;
	// divide by 32 plus removal of the guard bits
	localparam int OUT_SHIFT = LOG2_N + GUARD_BITS;

	localparam int TW_W = 18;
	localparam int TW_FRAC = 16;

	typedef logic signed [IO_W-1:0] io_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [LOG2_N-1:0] addr_t;
	typedef logic [2:0] stage_t;
	typedef logic [3:0] tw_idx_t;

	// e^{+j 2 pi k / 32}, rounded to Q1.16
	localparam logic signed [TW_W-1:0] TW_COS [N_BFY] = '{
		18'sd65536, 18'sd64277, 18'sd60547, 18'sd54491,
		18'sd46341, 18'sd36410, 18'sd25080, 18'sd12785,
		18'sd0, -18'sd12785, -18'sd25080, -18'sd36410,
		-18'sd46341, -18'sd54491, -18'sd60547, -18'sd64277
	};

	localparam logic signed [TW_W-1:0] TW_SIN [N_BFY] = '{
		18'sd0, 18'sd12785, 18'sd25080, 18'sd36410,
		18'sd46341, 18'sd54491, 18'sd60547, 18'sd64277,
		18'sd65536, 18'sd64277, 18'sd60547, 18'sd54491,
		18'sd46341, 18'sd36410, 18'sd25080, 18'sd12785
	};

	typedef enum logic [1:0] {
		ST_LOAD,
		ST_COMPUTE,
		ST_UNLOAD
	} ctrl_state_e;

endpackage

// File: source/ifft_sample_bank.sv
// load writes and butterfly write-backs never overlap since they belong to different phases
module ifft_sample_bank
	import ifft_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  ctrl_state_e state,
	input  logic        pushin,
	input  addr_t       wr_addr,
	input  io_t         dir,
	input  io_t         dii,
	input  addr_t       rd_addr_a,
	input  addr_t       rd_addr_b,
	input  logic        wb_valid,
	input  addr_t       wb_addr_a,
	input  addr_t       wb_addr_b,
	input  acc_t        wb_ar,
	input  acc_t        wb_ai,
	input  acc_t        wb_br,
	input  acc_t        wb_bi,
	output acc_t        rd_ar,
	output acc_t        rd_ai,
	output acc_t        rd_br,
	output acc_t        rd_bi
);

	acc_t mem_r [N_POINTS];
	acc_t mem_i [N_POINTS];
	acc_t in_r;
	acc_t in_i;
	logic load_we;

	assign load_we = pushin && (state == ST_LOAD);

	// sign extend, then four guard bits
	assign in_r = acc_t'(dir) <<< GUARD_BITS;
	assign in_i = acc_t'(dii) <<< GUARD_BITS;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < N_POINTS; i++) begin
				mem_r[i] <= '0;
				mem_i[i] <= '0;
			end
		end else if (load_we) begin
			mem_r[wr_addr] <= in_r;
			mem_i[wr_addr] <= in_i;
		end else if (wb_valid) begin
			// in-place update of both butterfly legs
			mem_r[wb_addr_a] <= wb_ar;
			mem_i[wb_addr_a] <= wb_ai;
			mem_r[wb_addr_b] <= wb_br;
			mem_i[wb_addr_b] <= wb_bi;
		end
	end

	assign rd_ar = mem_r[rd_addr_a];
	assign rd_ai = mem_i[rd_addr_a];
	assign rd_br = mem_r[rd_addr_b];
	assign rd_bi = mem_i[rd_addr_b];

endmodule

// File: source/ifft_step_counter.sv
// BFY_LATENCY must equal the butterfly latency so each stage fully drains before the next
module ifft_step_counter
	import ifft_pkg::*;
#(
	parameter int BFY_LATENCY = 3
) (
	input  logic        clk,
	input  logic        rst,
	input  ctrl_state_e state,
	input  logic        pushin,
	output addr_t       wr_addr,
	output addr_t       rd_addr_a,
	output addr_t       rd_addr_b,
	output tw_idx_t     tw_idx,
	output logic        issue,
	output logic        phase_done
);

	localparam int STAGE_LEN = N_BFY + BFY_LATENCY;
	localparam int CNT_W = $clog2(N_POINTS + STAGE_LEN);

	logic [CNT_W-1:0] cnt;
	stage_t stage;
	logic load_take;
	logic stage_end;
	logic [LOG2_N-2:0] bfy;
	logic [LOG2_N-2:0] pos_mask;
	logic [LOG2_N-2:0] pos;
	addr_t span;
	addr_t upper;
	addr_t unload_idx;
	addr_t unload_addr;

	assign load_take = (state == ST_LOAD) && pushin;
	assign stage_end = (state == ST_COMPUTE) && (cnt == CNT_W'(STAGE_LEN - 1));
	assign issue = (state == ST_COMPUTE) && (cnt < CNT_W'(N_BFY));

	// dif pair for step bfy of the current stage
	assign bfy = cnt[LOG2_N-2:0];
	assign span = addr_t'(N_BFY) >> stage;
	assign pos_mask = {(LOG2_N - 1){1'b1}} >> stage;
	assign pos = bfy & pos_mask;
	assign upper = {bfy & ~pos_mask, 1'b0} | addr_t'(pos);
	assign tw_idx = pos << stage;

	// unload cycle 0 is idle, so reads run one count behind
	assign unload_idx = addr_t'(cnt - 1'b1);
	assign unload_addr = {<<{unload_idx}};

	assign wr_addr = cnt[LOG2_N-1:0];
	assign rd_addr_a = (state == ST_UNLOAD) ? unload_addr : upper;
	assign rd_addr_b = upper + span;

	always_comb begin
		case (state)
			ST_LOAD: begin
				phase_done = load_take && (cnt == CNT_W'(N_POINTS - 1));
			end
			ST_COMPUTE: begin
				phase_done = stage_end && (stage == stage_t'(LOG2_N - 1));
			end
			ST_UNLOAD: begin
				phase_done = (cnt == CNT_W'(N_POINTS));
			end
			default: begin
				phase_done = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst || phase_done) begin
			cnt <= '0;
			stage <= '0;
		end else if (stage_end) begin
			cnt <= '0;
			stage <= stage + 1'b1;
		end else if (load_take || (state != ST_LOAD)) begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

// File: source/ifft_unload.sv
// truncates toward zero; results that exceed 28 bits after the shift wrap silently
module ifft_unload
	import ifft_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  ctrl_state_e state,
	input  acc_t        rd_ar,
	input  acc_t        rd_ai,
	output logic        pushout,
	output io_t         dor,
	output io_t         doi
);

	logic unload_q;

	// symmetric shift: magnitude, shift, restore sign
	function automatic io_t scale_out(acc_t v);
		acc_t mag;
		acc_t shifted;
		mag = v[ACC_W-1] ? -v : v;
		shifted = mag >> OUT_SHIFT;
		return io_t'(v[ACC_W-1] ? -shifted : shifted);
	endfunction

	// no read is issued in the first unload cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			unload_q <= 1'b0;
			pushout <= 1'b0;
		end else begin
			unload_q <= (state == ST_UNLOAD);
			pushout <= (state == ST_UNLOAD) && unload_q;
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_UNLOAD) begin
			dor <= scale_out(rd_ar);
			doi <= scale_out(rd_ai);
		end
	end

endmodule

// File: verification/ifft_sva.sv
// output side only; assumes every pushout burst is exactly one 32-sample frame
module ifft_sva
	import ifft_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic pushout,
	input io_t  dor,
	input io_t  doi
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [6:0] run_len;

	// length of the current pushout burst
	always_ff @(posedge clk) begin
		if (rst || !pushout) begin
			run_len <= '0;
		end else begin
			run_len <= run_len + 7'd1;
		end
	end

	reset_quiet: assert property (@(posedge clk) rst |=> !pushout)
		else $error("pushout high in the cycle after reset");

	burst_max: assert property (@(posedge clk) disable iff (rst) pushout |-> run_len < 7'd32)
		else $error("pushout burst longer than one frame");

	burst_len: assert property (@(posedge clk) disable iff (rst) $fell(pushout) |-> run_len == 7'd32)
		else $error("pushout burst shorter than one frame");

	known_data: assert property (@(posedge clk) disable iff (rst) pushout |-> !$isunknown({dor, doi}))
		else $error("unknown bits on dor or doi during pushout");

endmodule

// File: verification/ifft_tb.sv
// LCG frames with magnitudes below 2^22 so no stage wraps; default butterfly latency of 3 assumed
module ifft_tb
	import ifft_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int BFY_LATENCY = 3;
	localparam int N_FRAMES = 20;
	localparam int RESET_CYCLES = 8;
	localparam int FIRST_OUT = LOG2_N * (N_BFY + BFY_LATENCY) + 2;
	localparam int CYCLE_LIMIT = N_FRAMES * 300 + RESET_CYCLES;
	localparam longint IMPULSE_VAL = -1234567;
	localparam longint CONST_VAL = 987654;

	logic clk;
	logic rst;
	logic pushin;
	io_t dir;
	io_t dii;
	logic pushout;
	io_t dor;
	io_t doi;

	logic [31:0] rng_state;
	int cycle = 0;
	longint in_r [N_POINTS];
	longint in_i [N_POINTS];
	longint exp_r [N_POINTS];
	longint exp_i [N_POINTS];

	ifft #(
		.BFY_LATENCY(BFY_LATENCY)
	) dut_i (
		.clk(clk),
		.rst(rst),
		.pushin(pushin),
		.dir(dir),
		.dii(dii),
		.pushout(pushout),
		.dor(dor),
		.doi(doi)
	);

	bind ifft ifft_sva sva_i (
		.clk(clk),
		.rst(rst),
		.pushout(pushout),
		.dor(dor),
		.doi(doi)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle > CYCLE_LIMIT) begin
			$display("Verification failed");
			$fatal(1, "run went past %0d cycles without finishing all frames", CYCLE_LIMIT);
		end
	end

	task automatic check_value(string name, logic signed [63:0] actual,
			logic signed [63:0] expected);
		if (actual !== expected) begin
			$display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, actual, expected);
			$display("Verification failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	// upper bits only, magnitude below 2^22
	function automatic longint rand_sample();
		logic [31:0] r;
		r = next_rand();
		return r[31] ? -longint'(r[30:9]) : longint'(r[30:9]);
	endfunction

	function automatic longint wrap_acc(longint v);
		logic signed [ACC_W-1:0] w;
		w = v[ACC_W-1:0];
		return longint'(w);
	endfunction

	function automatic int bit_reverse(int k);
		int r;
		r = 0;
		for (int i = 0; i < LOG2_N; i++) begin
			r = (r << 1) | ((k >> i) & 1);
		end
		return r;
	endfunction

	// truncate toward zero, keep the low IO_W bits
	function automatic longint shift_out(longint v);
		longint t;
		logic signed [IO_W-1:0] n;
		t = (v < 0) ? -((-v) >>> OUT_SHIFT) : (v >>> OUT_SHIFT);
		n = t[IO_W-1:0];
		return longint'(n);
	endfunction

	// kind 0 random, 1 impulse at index 0, 2 constant real
	task automatic fill_frame(int kind);
		for (int k = 0; k < N_POINTS; k++) begin
			if (kind == 1) begin
				in_r[k] = (k == 0) ? IMPULSE_VAL : 0;
				in_i[k] = 0;
			end else if (kind == 2) begin
				in_r[k] = CONST_VAL;
				in_i[k] = 0;
			end else begin
				in_r[k] = rand_sample();
				in_i[k] = rand_sample();
			end
		end
	endtask

	// upshift, five dif stages in place, bit-reversed read
	task automatic run_model();
		longint br [N_POINTS];
		longint bi [N_POINTS];
		longint dr;
		longint di;
		longint prod_r;
		longint prod_i;
		int span;
		int pos;
		int up;
		int lo;
		int tw;
		for (int k = 0; k < N_POINTS; k++) begin
			br[k] = in_r[k] <<< GUARD_BITS;
			bi[k] = in_i[k] <<< GUARD_BITS;
		end
		for (int s = 0; s < LOG2_N; s++) begin
			span = N_BFY >> s;
			for (int b = 0; b < N_BFY; b++) begin
				pos = b % span;
				up = (b / span) * 2 * span + pos;
				lo = up + span;
				tw = pos << s;
				dr = wrap_acc(br[up] - br[lo]);
				di = wrap_acc(bi[up] - bi[lo]);
				br[up] = wrap_acc(br[up] + br[lo]);
				bi[up] = wrap_acc(bi[up] + bi[lo]);
				prod_r = dr * TW_COS[tw] - di * TW_SIN[tw];
				prod_i = dr * TW_SIN[tw] + di * TW_COS[tw];
				br[lo] = wrap_acc(prod_r >>> TW_FRAC);
				bi[lo] = wrap_acc(prod_i >>> TW_FRAC);
			end
		end
		for (int k = 0; k < N_POINTS; k++) begin
			exp_r[k] = shift_out(br[bit_reverse(k)]);
			exp_i[k] = shift_out(bi[bit_reverse(k)]);
		end
	endtask

	// returns the cycle number of the edge that takes the last sample
	task automatic load_frame(bit gaps, output int take_cycle);
		int idle;
		for (int k = 0; k < N_POINTS; k++) begin
			idle = gaps ? int'(next_rand() >> 30) : 0;
			repeat (idle) begin
				@(negedge clk);
				check_value("pushout", pushout, 0);
				pushin = 1'b0;
			end
			@(negedge clk);
			check_value("pushout", pushout, 0);
			pushin = 1'b1;
			dir = io_t'(in_r[k]);
			dii = io_t'(in_i[k]);
		end
		take_cycle = cycle + 1;
	endtask

	task automatic collect_frame(int take_cycle, bit junk, int kind);
		logic [31:0] r;
		@(negedge clk);
		while (pushout !== 1'b1) begin
			r = next_rand();
			pushin = junk && r[31];
			dir = io_t'(r);
			dii = io_t'(~r);
			@(negedge clk);
		end
		check_value("first pushout cycle", cycle, take_cycle + FIRST_OUT);
		for (int k = 0; k < N_POINTS; k++) begin
			if (k > 0) begin
				@(negedge clk);
			end
			check_value("pushout", pushout, 1);
			check_value("dor", dor, exp_r[k]);
			check_value("doi", doi, exp_i[k]);
			if (kind == 1) begin
				check_value("dor", dor, IMPULSE_VAL / N_POINTS);
				check_value("doi", doi, 0);
			end else if (kind == 2) begin
				check_value("dor", dor, (k == 0) ? CONST_VAL : 0);
				check_value("doi", doi, 0);
			end
			// the last output edge is already back in load
			r = next_rand();
			pushin = junk && r[31] && (k < N_POINTS - 1);
			dir = io_t'(r);
			dii = io_t'(~r);
		end
	endtask

	initial begin
		int take_cycle;
		int kind;
		bit gaps;
		bit junk;
		rng_state = 32'd81699;
		rst = 1'b1;
		pushin = 1'b0;
		dir = '0;
		dii = '0;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_value("pushout", pushout, 0);
		end
		rst = 1'b0;
		for (int f = 0; f < N_FRAMES; f++) begin
			kind = (f < 2) ? f + 1 : 0;
			gaps = (f >= 8);
			junk = (f >= 14);
			fill_frame(kind);
			run_model();
			load_frame(gaps, take_cycle);
			collect_frame(take_cycle, junk, kind);
		end
		$display("Verification passed");
		$finish;
	end

endmodule
